// ==== source/cache_pkg.sv ====
// geometry fixed at 128 direct mapped blocks of eight 16-bit words, word addressed, bit 0 ignored
`default_nettype none

package cache_pkg;

	localparam int TAG_W           = 5;
	localparam int INDEX_W         = 7;
	localparam int OFFSET_W        = 3;
	localparam int NUM_BLOCKS      = 128;       // one block per index, direct mapped
	localparam int WORDS_PER_BLOCK = 8;
	localparam int WORD_W          = 16;        // also the address width

	// address split as the arrays see it
	typedef struct packed {
		logic [TAG_W-1:0]    tag;       // bits 15:11
		logic [INDEX_W-1:0]  index;     // bits 10:4
		logic [OFFSET_W-1:0] offset;    // word within block, bits 3:1
		logic                zero;      // byte bit, always 0 for word accesses
	} addr_fields_t;

	// raw view for memory requests, field view for the arrays
	typedef union packed {
		logic [WORD_W-1:0] raw;
		addr_fields_t      f;
	} cache_addr_u;

	// one metadata entry per block
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
	} meta_t;

	// fill engine states
	// IDLE also serves hits, bypass reads and the miss cycle itself
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		FILL      = 2'd1,   // one read_req per word, offsets 0 to 7
		WRITE_TAG = 2'd2    // tag and valid written last
	} fill_state_e;

endpackage

`default_nettype wire

// ==== source/mem_pkg.sv ====
// memory side carries one 16-bit word per strobe, config port has three 16-bit registers only
`default_nettype none

package mem_pkg;

	localparam int CFG_DATA_W = 16;   // config data and counter width

	// config register map
	localparam logic [1:0] CFG_CTRL   = 2'd0;   // bit 0 enable, bit 1 invalidate strobe
	localparam logic [1:0] CFG_HITS   = 2'd1;   // write clears
	localparam logic [1:0] CFG_MISSES = 2'd2;   // write clears

	// cache to memory
	typedef struct packed {
		logic        read_req;   // level, held with addr until mem_data_valid
		logic        wrt_mem;    // single cycle, memory completes in that cycle
		logic [15:0] addr;
		logic [15:0] wdata;
	} mem_req_t;

	// memory to cache
	typedef struct packed {
		logic        mem_data_valid;   // one cycle pulse
		logic [15:0] mem_data;
	} mem_rsp_t;

	// register block outputs
	typedef struct packed {
		logic enable;       // clear means every access bypasses the arrays
		logic invalidate;   // one cycle, clears all valid bits at the edge
	} ctrl_t;

endpackage

`default_nettype wire

// ==== source/cache_fill_fsm.sv ====
// expects mem_en, wrt_cmd, addr_in and wdata held stable while fsm_busy is high; one read in flight
`default_nettype none
`timescale 1ns/1ps

module cache_fill_fsm (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          mem_en,       // access strobe
	input  logic                          wrt_cmd,      // high for a write
	input  cache_pkg::cache_addr_u        addr_in,
	input  logic [cache_pkg::WORD_W-1:0]  wdata,
	input  cache_pkg::meta_t              meta,         // entry at cache_addr index
	input  mem_pkg::ctrl_t                ctrl,
	input  mem_pkg::mem_rsp_t             rsp,
	output mem_pkg::mem_req_t             req,
	output cache_pkg::cache_addr_u        cache_addr,   // address into the arrays
	output logic                          wrt_data,     // data array word write
	output logic                          wrt_tag,      // metadata write, sets valid
	output logic                          fill_sel,     // mem_data onto array input and data_out
	output logic                          fsm_busy,     // pipeline stall
	output logic                          hit_evt,
	output logic                          miss_evt
);
	import cache_pkg::*;

	fill_state_e         state;
	fill_state_e         nxt_state;
	logic [OFFSET_W-1:0] cnt;         // offset of the word being fetched
	logic                fill_done;   // tag written last cycle
	logic                hit;
	logic                cached;      // access with the cache enabled
	logic                bypass;      // access with the cache disabled

	assign hit    = meta.valid && (meta.tag == addr_in.f.tag);
	assign cached = mem_en && ctrl.enable;
	assign bypass = mem_en && !ctrl.enable;

	// tag and index always from addr_in, offset walks during a fill
	always_comb begin
		cache_addr = addr_in;
		if (state != IDLE)
			cache_addr.f.offset = cnt;
	end

	always_comb begin
		nxt_state    = state;
		req          = '0;
		req.addr     = cache_addr.raw;   // fill address or addr_in
		req.wdata    = wdata;
		wrt_data     = 1'b0;
		wrt_tag      = 1'b0;
		fill_sel     = 1'b0;
		fsm_busy     = 1'b0;
		hit_evt      = 1'b0;
		miss_evt     = 1'b0;
		case (state)
			IDLE: begin
				if (cached && hit) begin
					hit_evt     = !fill_done;   // the refilled access is not a hit
					wrt_data    = wrt_cmd;      // write through, array and memory together
					req.wrt_mem = wrt_cmd;
				end else if (cached) begin
					miss_evt  = 1'b1;           // only once, the next cycle is FILL
					fsm_busy  = 1'b1;
					nxt_state = FILL;
				end else if (bypass) begin
					req.wrt_mem  = wrt_cmd;
					req.read_req = !wrt_cmd;
					fill_sel     = !wrt_cmd;    // data_out shows mem_data
					fsm_busy     = !wrt_cmd && !rsp.mem_data_valid;
				end
			end
			FILL: begin
				req.read_req = 1'b1;            // addr stays put until the word returns
				fsm_busy     = 1'b1;
				if (rsp.mem_data_valid) begin
					wrt_data = 1'b1;
					fill_sel = 1'b1;
					if (cnt == OFFSET_W'(WORDS_PER_BLOCK - 1))
						nxt_state = WRITE_TAG;
				end
			end
			WRITE_TAG: begin
				wrt_tag   = 1'b1;
				fsm_busy  = 1'b1;               // drops next cycle, access then hits
				nxt_state = IDLE;
			end
			default: nxt_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			cnt       <= '0;
			fill_done <= 1'b0;
		end else begin
			state     <= nxt_state;
			fill_done <= (state == WRITE_TAG);
			if (state == FILL && rsp.mem_data_valid)
				cnt <= cnt + 1'b1;   // wraps to 0 after the last word
			else if (state == IDLE)
				cnt <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/meta_data_array.sv ====
// asynchronous read of valid and tag, invalidate beats a tag write in the same cycle
`default_nettype none
`timescale 1ns/1ps

module meta_data_array (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cache_pkg::INDEX_W-1:0] index,
	input  logic                          wr,           // tag write, marks block valid
	input  logic [cache_pkg::TAG_W-1:0]   tag_in,
	input  logic                          invalidate,   // clears every valid bit
	output cache_pkg::meta_t              meta
);
	import cache_pkg::*;

	logic [NUM_BLOCKS-1:0] valid;                // one bit per block
	logic [TAG_W-1:0]      tags [NUM_BLOCKS];    // meaningless while valid is clear

	// reset and invalidate clear every valid bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid <= '0;
		else if (invalidate)
			valid <= '0;
		else if (wr)
			valid[index] <= 1'b1;
	end

	// tag storage
	always_ff @(posedge clk) begin
		if (wr)
			tags[index] <= tag_in;
	end

	assign meta = {valid[index], tags[index]};   // read path, same cycle

endmodule

`default_nettype wire

// ==== source/data_array.sv ====
// no reset, contents are undefined until a block is filled; one word written per edge
`default_nettype none
`timescale 1ns/1ps

module data_array (
	input  logic                           clk,
	input  logic [cache_pkg::INDEX_W-1:0]  index,
	input  logic [cache_pkg::OFFSET_W-1:0] offset,
	input  logic                           wr,
	input  logic [cache_pkg::WORD_W-1:0]   din,
	output logic [cache_pkg::WORD_W-1:0]   dout
);
	import cache_pkg::*;

	// block by word storage
	logic [WORD_W-1:0] mem [NUM_BLOCKS][WORDS_PER_BLOCK];

	always_ff @(posedge clk) begin
		if (wr)
			mem[index][offset] <= din;   // fill word or write-through data
	end

	// read is combinational so a hit returns in the access cycle
	assign dout = mem[index][offset];

endmodule

`default_nettype wire

// ==== source/cache_ctrl_regs.sv ====
// enable resets to 1, counters saturate at all ones, a counter clear wins over an event
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl_regs (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            cfg_wr,
	input  logic [1:0]                      cfg_addr,
	input  logic [mem_pkg::CFG_DATA_W-1:0]  cfg_wdata,
	input  logic                            hit_evt,
	input  logic                            miss_evt,
	output logic [mem_pkg::CFG_DATA_W-1:0]  cfg_rdata,
	output mem_pkg::ctrl_t                  ctrl
);
	import mem_pkg::*;

	logic                       enable;
	logic                       ctrl_wr;   // write to CFG_CTRL
	logic [1:0][CFG_DATA_W-1:0] cnt;       // [0] hits, [1] misses
	logic [1:0]                 evt;
	logic [1:0]                 clr;

	assign ctrl_wr = cfg_wr && (cfg_addr == CFG_CTRL);
	assign evt     = {miss_evt, hit_evt};
	assign clr[0]  = cfg_wr && (cfg_addr == CFG_HITS);
	assign clr[1]  = cfg_wr && (cfg_addr == CFG_MISSES);

	// invalidate is the write strobe itself, valid bits clear at the same edge
	assign ctrl = {enable, ctrl_wr && cfg_wdata[1]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable <= 1'b1;   // cache on out of reset
			cnt    <= '0;
		end else begin
			if (ctrl_wr)
				enable <= cfg_wdata[0];
			for (int i = 0; i < 2; i++) begin
				if (clr[i])
					cnt[i] <= '0;
				else if (evt[i] && !(&cnt[i]))
					cnt[i] <= cnt[i] + 1'b1;   // hold at max
			end
		end
	end

	// readback straight from cfg_addr
	always_comb begin
		case (cfg_addr)
			CFG_CTRL:   cfg_rdata = CFG_DATA_W'(enable);
			CFG_HITS:   cfg_rdata = cnt[0];
			CFG_MISSES: cfg_rdata = cnt[1];
			default:    cfg_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/dcache.sv ====
// write-through write-allocate data cache, no byte writes, a single outstanding memory read
`default_nettype none
`timescale 1ns/1ps

module dcache (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           mem_en,      // held until fsm_busy is low
	input  logic                           wrt_cmd,
	input  cache_pkg::cache_addr_u         addr_in,
	input  logic [cache_pkg::WORD_W-1:0]   wdata,
	output logic [cache_pkg::WORD_W-1:0]   data_out,
	output logic                           fsm_busy,    // stall
	output mem_pkg::mem_req_t              req,         // to memory
	input  mem_pkg::mem_rsp_t              rsp,         // from memory
	input  logic                           cfg_wr,
	input  logic [1:0]                     cfg_addr,
	input  logic [mem_pkg::CFG_DATA_W-1:0] cfg_wdata,
	output logic [mem_pkg::CFG_DATA_W-1:0] cfg_rdata
);
	import cache_pkg::*;
	import mem_pkg::*;

	cache_addr_u       cache_addr;   // addr_in, offset replaced during a fill
	meta_t             meta;
	ctrl_t             ctrl;
	logic              wrt_data;
	logic              wrt_tag;
	logic              fill_sel;
	logic              hit_evt;
	logic              miss_evt;
	logic [WORD_W-1:0] din;
	logic [WORD_W-1:0] dout;

	// fill words come from memory, write hits from the processor
	assign din      = fill_sel ? rsp.mem_data : wdata;
	assign data_out = fill_sel ? rsp.mem_data : dout;   // bypass read shows memory word

	cache_fill_fsm u_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_en     (mem_en),
		.wrt_cmd    (wrt_cmd),
		.addr_in    (addr_in),
		.wdata      (wdata),
		.meta       (meta),
		.ctrl       (ctrl),
		.rsp        (rsp),
		.req        (req),
		.cache_addr (cache_addr),
		.wrt_data   (wrt_data),
		.wrt_tag    (wrt_tag),
		.fill_sel   (fill_sel),
		.fsm_busy   (fsm_busy),
		.hit_evt    (hit_evt),
		.miss_evt   (miss_evt)
	);

	meta_data_array u_meta (
		.clk        (clk),
		.rst_n      (rst_n),
		.index      (cache_addr.f.index),
		.wr         (wrt_tag),
		.tag_in     (cache_addr.f.tag),
		.invalidate (ctrl.invalidate),
		.meta       (meta)
	);

	data_array u_data (
		.clk    (clk),
		.index  (cache_addr.f.index),
		.offset (cache_addr.f.offset),
		.wr     (wrt_data),
		.din    (din),
		.dout   (dout)
	);

	cache_ctrl_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.hit_evt   (hit_evt),
		.miss_evt  (miss_evt),
		.cfg_rdata (cfg_rdata),
		.ctrl      (ctrl)
	);

endmodule

`default_nettype wire

// ==== verification/dcache_chk.sv ====
// bound into cache_fill_fsm, sampled on clk; assumes mem_en is held until fsm_busy falls
`default_nettype none
`timescale 1ns/1ps

module dcache_chk (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   mem_en,
	input cache_pkg::fill_state_e state,
	input logic                   fsm_busy,
	input mem_pkg::mem_req_t      req,
	input mem_pkg::mem_rsp_t      rsp
);
	import cache_pkg::*;

	// one memory command per cycle
	a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		!(req.read_req && req.wrt_mem))
		else $error("read_req and wrt_mem high in the same cycle");

	// request held with its address until the word comes back
	a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		req.read_req && !rsp.mem_data_valid |=> req.read_req && $stable(req.addr))
		else $error("read_req dropped or addr moved before mem_data_valid");

	// the held access hits once its tag is written, so the stall ends in IDLE
	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		state == WRITE_TAG && mem_en |=> state == IDLE && !fsm_busy)
		else $error("fsm_busy still high in IDLE after the tag write");

endmodule

bind cache_fill_fsm dcache_chk u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.mem_en   (mem_en),
	.state    (state),
	.fsm_busy (fsm_busy),
	.req      (req),
	.rsp      (rsp)
);

`default_nettype wire

// ==== verification/dcache_tb.sv ====
// drives on falling edges and samples 1 ns later; memory is a word image at addr[15:1] with a fill pattern
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;
	import cache_pkg::*;
	import mem_pkg::*;

	localparam int WAIT_LIMIT = 64;   // cycles, a fill needs at most 8 words of 4 cycles

	logic        clk;
	logic        rst_n;
	logic        mem_en;
	logic        wrt_cmd;
	cache_addr_u addr_in;
	logic [15:0] wdata;
	logic [15:0] data_out;
	logic        fsm_busy;
	mem_req_t    req;
	mem_rsp_t    rsp;
	logic        cfg_wr;
	logic [1:0]  cfg_addr;
	logic [15:0] cfg_wdata;
	logic [15:0] cfg_rdata;

	logic [15:0]           mem_img [32768];   // memory model contents
	logic [15:0]           ref_img [32768];   // what memory should hold
	logic [15:0]           ref_data [NUM_BLOCKS][WORDS_PER_BLOCK];
	logic [NUM_BLOCKS-1:0] ref_valid;
	logic [TAG_W-1:0]      ref_tag [NUM_BLOCKS];
	logic                  ref_en;
	logic [15:0]           ref_hits;
	logic [15:0]           ref_misses;
	logic [15:0]           lfsr;
	logic [15:0]           rd_q [$];          // read_req addresses of the current access
	logic [15:0]           rd_addr;
	logic [2:0]            delay;             // cycles left before mem_data_valid
	logic                  pending;
	logic                  saw_busy;
	int                    errors;
	int                    timeouts;

	dcache uut (.*);

	always #2 clk = ~clk;

	function automatic logic [15:0] fill_word(input logic [14:0] w);
		return 16'hA5C3 ^ {w[7:0], w[14:7]};   // every address bit counts
	endfunction

	// fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);   // one step per bit
			v    = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// expected data_out of a completed access, kind is 0 hit, 1 fill then hit, 2 bypass
	function automatic logic [15:0] ref_access(input logic wr, input logic [15:0] a,
			input logic [15:0] d, output logic [1:0] kind);
		logic [INDEX_W-1:0]  idx;
		logic [OFFSET_W-1:0] off;
		idx  = a[10:4];
		off  = a[3:1];
		kind = 2'd2;
		if (ref_en) begin
			kind = (ref_valid[idx] && ref_tag[idx] == a[15:11]) ? 2'd0 : 2'd1;
			if (kind == 2'd1) begin
				for (int k = 0; k < WORDS_PER_BLOCK; k++)
					ref_data[idx][k] = ref_img[{a[15:4], 3'(k)}];
				ref_valid[idx] = 1'b1;
				ref_tag[idx]   = a[15:11];
				if (ref_misses != 16'hFFFF)
					ref_misses++;
			end else if (ref_hits != 16'hFFFF)
				ref_hits++;
			if (wr)
				ref_data[idx][off] = d;
		end
		if (wr)
			ref_img[a[15:1]] = d;   // write-through or bypass, memory always sees it
		return ref_en ? ref_data[idx][off] : ref_img[a[15:1]];
	endfunction

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	// memory model, answers 1 to 4 cycles after read_req
	initial begin
		rsp     = '0;
		pending = 1'b0;
		forever begin
			@(negedge clk);
			rsp.mem_data_valid = 1'b0;
			if (pending) begin
				delay = delay - 3'd1;
				if (delay == 3'd0) begin
					rsp.mem_data_valid = 1'b1;
					rsp.mem_data       = mem_img[rd_addr[15:1]];
				end
			end
			#1;
			if (req.wrt_mem)
				mem_img[req.addr[15:1]] = req.wdata;   // done within the pulse
			if (rsp.mem_data_valid)
				pending = 1'b0;                        // word taken this cycle
			else if (req.read_req && !pending) begin
				pending = 1'b1;
				rd_addr = req.addr;
				delay   = 3'(take_bits(2)) + 3'd1;
				rd_q.push_back(req.addr);
			end
		end
	end

	// compare process, one check set per completed access
	always begin
		logic [1:0]  kind;
		logic [15:0] exp;
		int          n;
		@(negedge clk);
		#1;
		if (rst_n && mem_en && fsm_busy) begin
			saw_busy = 1'b1;
			check("req.wrt_mem", 16'(req.wrt_mem), 16'd0);   // nothing written while stalled
		end else if (rst_n && mem_en) begin
			exp = ref_access(wrt_cmd, addr_in.raw, wdata, kind);
			n   = (kind == 2'd1) ? 8 : ((kind == 2'd2 && !wrt_cmd) ? 1 : 0);
			check("fsm_busy", 16'(saw_busy), 16'(n != 0));
			check("req.wrt_mem", 16'(req.wrt_mem), 16'(wrt_cmd));
			if (wrt_cmd) begin
				check("req.addr", req.addr, addr_in.raw);
				check("req.wdata", req.wdata, wdata);
			end else
				check("data_out", data_out, exp);
			check("read_req count", 16'(rd_q.size()), 16'(n));
			for (int k = 0; k < rd_q.size() && k < n; k++)
				check("req.addr", rd_q[k], (n == 1) ? addr_in.raw : {addr_in.raw[15:4], 3'(k), 1'b0});
			rd_q.delete();
			saw_busy = 1'b0;
		end
	end

	task automatic access(input logic wr, input logic [15:0] a, input logic [15:0] d);
		int n;
		@(negedge clk);
		mem_en      = 1'b1;
		wrt_cmd     = wr;
		addr_in.raw = a;
		wdata       = d;
		n           = 0;
		#1;
		while (fsm_busy && n < WAIT_LIMIT) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (fsm_busy) begin
			timeouts++;
			$display("timeout: access to %h still stalled after %0d cycles", a, WAIT_LIMIT);
		end
		@(negedge clk);
		mem_en  = 1'b0;
		wrt_cmd = 1'b0;
	endtask

	task automatic cfg_write(input logic [1:0] a, input logic [15:0] d);
		@(negedge clk);
		cfg_wr    = 1'b1;
		cfg_addr  = a;
		cfg_wdata = d;
		@(negedge clk);
		cfg_wr = 1'b0;
		if (a == CFG_CTRL) begin
			ref_en = d[0];
			if (d[1])
				ref_valid = '0;   // invalidate all
		end else if (a == CFG_HITS)
			ref_hits = '0;
		else if (a == CFG_MISSES)
			ref_misses = '0;
	endtask

	task automatic cfg_expect(input logic [1:0] a, input logic [15:0] exp, input string name);
		@(negedge clk);
		cfg_addr = a;
		#1;
		check(name, cfg_rdata, exp);
	endtask

	initial begin
		logic [15:0] a;
		logic [15:0] d;
		clk       = 1'b0;
		rst_n     = 1'b0;
		mem_en    = 1'b0;
		wrt_cmd   = 1'b0;
		addr_in   = '0;
		wdata     = '0;
		cfg_wr    = 1'b0;
		cfg_addr  = CFG_CTRL;
		cfg_wdata = '0;
		lfsr      = 16'd50432;
		ref_en    = 1'b1;
		ref_hits  = '0;
		ref_misses = '0;
		ref_valid = '0;
		saw_busy  = 1'b0;
		errors    = 0;
		timeouts  = 0;
		for (int k = 0; k < 32768; k++) begin
			mem_img[k] = fill_word(15'(k));
			ref_img[k] = fill_word(15'(k));
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		check("req.read_req", 16'(req.read_req), 16'd0);
		check("req.wrt_mem", 16'(req.wrt_mem), 16'd0);
		check("fsm_busy", 16'(fsm_busy), 16'd0);
		access(1'b0, 16'h1234, 16'h0);   // cold miss, full block fill
		access(1'b0, 16'h1236, 16'h0);   // same block, hits
		access(1'b0, 16'h1234, 16'h0);
		d = take_bits(16);
		access(1'b1, 16'h1238, d);       // write hit
		access(1'b0, 16'h1238, 16'h0);
		d = take_bits(16);
		access(1'b1, 16'h2A40, d);       // write miss, allocates
		access(1'b0, 16'h2A40, 16'h0);
		access(1'b0, 16'h9234, 16'h0);   // index 0x23 again, other tag evicts
		access(1'b0, 16'h1234, 16'h0);
		cfg_write(CFG_CTRL, 16'h0003);   // enable stays on, all blocks invalid
		access(1'b0, 16'h1234, 16'h0);
		cfg_write(CFG_CTRL, 16'h0000);
		cfg_expect(CFG_CTRL, 16'h0000, "cfg_rdata");
		access(1'b0, 16'h1236, 16'h0);   // bypass read
		access(1'b1, 16'h1236, 16'h0F0F);   // memory only, cached copy goes stale
		access(1'b0, 16'h7FFE, 16'h0);
		cfg_write(CFG_CTRL, 16'h0001);
		access(1'b0, 16'h1236, 16'h0);   // hits the stale copy
		for (int k = 0; k < 48; k++) begin
			a = take_bits(16) & 16'h187E;   // 4 tags, 8 indexes, any offset
			d = take_bits(16);
			access(d[0], a, d);
		end
		cfg_expect(CFG_HITS, ref_hits, "cfg_rdata");
		cfg_expect(CFG_MISSES, ref_misses, "cfg_rdata");
		cfg_write(CFG_HITS, 16'h0);
		cfg_write(CFG_MISSES, 16'h0);
		cfg_expect(CFG_HITS, 16'h0, "cfg_rdata");
		cfg_expect(CFG_MISSES, 16'h0, "cfg_rdata");
		$display("dcache_tb done, %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dcache.f ====
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_fill_fsm.sv
source/meta_data_array.sv
source/data_array.sv
source/cache_ctrl_regs.sv
source/dcache.sv
verification/dcache_chk.sv
verification/dcache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds dcache_tb with Verilator, runs it and checks the log for the pass line
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module dcache_tb --Mdir "$OBJ" -o dcache_sim \
	-f dcache.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/dcache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail, see $LOG"
exit 1
